//--- src/ver_pkg.sv
// version subsystem shared types
// control-port request/response, version records, status codes, register map
package ver_pkg;

  // --------------------------------------------------------------------------
  // control-port
  // --------------------------------------------------------------------------

  // response status codes, same encoding as the rfnoc control port
  typedef enum logic [1:0] {
    STS_OKAY    = 2'd0,
    STS_CMDERR  = 2'd1,
    STS_TSERR   = 2'd2,
    STS_WARNING = 2'd3
  } ctrlport_status_t;

  // single request, wr and rd are one-cycle strobes
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [19:0] addr;
    logic [31:0] data;
  } ctrlport_req_t;

  // single response, ack is a one-cycle pulse
  typedef struct packed {
    logic             ack;
    ctrlport_status_t status;
    logic [31:0]      data;
  } ctrlport_resp_t;

  // --------------------------------------------------------------------------
  // version words
  // --------------------------------------------------------------------------

  // msb-first fields, so a plain word compare orders versions
  typedef struct packed {
    logic [8:0]  major;
    logic [10:0] minor;
    logic [11:0] build;
  } version_t;

  // one 96-bit record per component
  typedef struct packed {
    logic [31:0] modified;
    version_t    oldest;
    version_t    current;
  } component_versions_t;

  // architectural limit on tracked components
  localparam int unsigned MAX_COMPONENTS = 64;

  // versioning window, 4 words per component
  localparam logic [3:0]  OFS_CURRENT         = 4'h0;
  localparam logic [3:0]  OFS_OLDEST          = 4'h4;
  localparam logic [3:0]  OFS_MODIFIED        = 4'h8;
  localparam logic [3:0]  OFS_RESERVED        = 4'hC;
  localparam int unsigned COMPONENT_STRIDE    = 16;
  localparam int unsigned VERSION_WINDOW_SIZE = 'h400;

  // compatibility window
  localparam logic [3:0]  OFS_SW_INDEX        = 4'h0;
  localparam logic [3:0]  OFS_SW_CURRENT      = 4'h4;
  localparam logic [3:0]  OFS_SW_OLDEST       = 4'h8;
  localparam logic [3:0]  OFS_COMPAT_STATUS   = 4'hC;
  localparam int unsigned COMPAT_WINDOW_SIZE  = 'h10;

endpackage

//--- src/ctrlport_decoder.sv
// control-port decoder for the version subsystem
// routes requests to the versioning or compatibility window, answers unmapped ones
`timescale 1ns/1ps

module ctrlport_decoder #(
  parameter int unsigned NUM_COMPONENTS = 8,
  parameter int unsigned VERSION_BASE   = 'h0000,
  parameter int unsigned COMPAT_BASE    = 'h0400
) (
  input  logic                    s_ctrlport_clk,
  input  logic                    s_ctrlport_rst,
  input  ver_pkg::ctrlport_req_t  s_ctrlport_req,
  output ver_pkg::ctrlport_resp_t s_ctrlport_resp,
  output ver_pkg::ctrlport_req_t  ver_req,
  output ver_pkg::ctrlport_req_t  compat_req,
  input  ver_pkg::ctrlport_resp_t ver_resp,
  input  ver_pkg::ctrlport_resp_t compat_resp
);

  // window end addresses, exclusive
  localparam int unsigned VER_LIMIT =
    VERSION_BASE + NUM_COMPONENTS * ver_pkg::COMPONENT_STRIDE;
  localparam int unsigned COMPAT_LIMIT = COMPAT_BASE + ver_pkg::COMPAT_WINDOW_SIZE;

  logic        busy;
  // one-hot route, bit 0 versioning, bit 1 compatibility
  logic [1:0]  route;
  logic [31:0] addr_full;
  logic        req_valid;
  logic        in_ver;
  logic        in_compat;
  logic [19:0] ver_ofs;
  logic [19:0] compat_ofs;
  logic        win_ack;
  ver_pkg::ctrlport_resp_t win_resp;

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------
  assign addr_full = 32'(s_ctrlport_req.addr);
  // requests while busy are dropped
  assign req_valid = (s_ctrlport_req.wr | s_ctrlport_req.rd) & ~busy;
  assign in_ver    = (addr_full >= VERSION_BASE) && (addr_full < VER_LIMIT);
  assign in_compat = (addr_full >= COMPAT_BASE) && (addr_full < COMPAT_LIMIT);

  // reduce to window offsets
  assign ver_ofs    = (s_ctrlport_req.addr - 20'(VERSION_BASE)) &
                      20'(ver_pkg::VERSION_WINDOW_SIZE - 1);
  assign compat_ofs = (s_ctrlport_req.addr - 20'(COMPAT_BASE)) &
                      20'(ver_pkg::COMPAT_WINDOW_SIZE - 1);

  // --------------------------------------------------------------------------
  // request forwarding, one cycle
  // --------------------------------------------------------------------------
  always_ff @(posedge s_ctrlport_clk) begin
    ver_req.addr    <= ver_ofs;
    ver_req.data    <= s_ctrlport_req.data;
    compat_req.addr <= compat_ofs;
    compat_req.data <= s_ctrlport_req.data;
    if (s_ctrlport_rst) begin
      ver_req.wr    <= 1'b0;
      ver_req.rd    <= 1'b0;
      compat_req.wr <= 1'b0;
      compat_req.rd <= 1'b0;
    end else begin
      // versioning wins if the windows were ever set to overlap
      ver_req.wr    <= req_valid & in_ver & s_ctrlport_req.wr;
      ver_req.rd    <= req_valid & in_ver & s_ctrlport_req.rd;
      compat_req.wr <= req_valid & ~in_ver & in_compat & s_ctrlport_req.wr;
      compat_req.rd <= req_valid & ~in_ver & in_compat & s_ctrlport_req.rd;
    end
  end

  // --------------------------------------------------------------------------
  // response merge
  // --------------------------------------------------------------------------
  assign win_resp = route[1] ? compat_resp : ver_resp;
  assign win_ack  = |(route & {compat_resp.ack, ver_resp.ack});

  // control path: ack, status, busy, route
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      s_ctrlport_resp.ack    <= 1'b0;
      s_ctrlport_resp.status <= ver_pkg::STS_OKAY;
      busy                   <= 1'b0;
      route                  <= 2'b00;
    end else begin
      s_ctrlport_resp.ack <= 1'b0;
      if (req_valid) begin
        busy  <= in_ver | in_compat;
        route <= {~in_ver & in_compat, in_ver};
        // unmapped, answer right away
        if (!in_ver && !in_compat) begin
          s_ctrlport_resp.ack    <= 1'b1;
          s_ctrlport_resp.status <= ver_pkg::STS_CMDERR;
        end
      end else if (win_ack) begin
        s_ctrlport_resp.ack    <= 1'b1;
        s_ctrlport_resp.status <= win_resp.status;
        busy                   <= 1'b0;
        route                  <= 2'b00;
      end
    end
  end

  // read data
  always_ff @(posedge s_ctrlport_clk) begin
    if (req_valid) begin
      s_ctrlport_resp.data <= '0;
    end else if (win_ack) begin
      s_ctrlport_resp.data <= win_resp.data;
    end
  end

endmodule

//--- src/versioning_regs.sv
// read-only versioning window
// per component current version, oldest compatible version and timestamp
`timescale 1ns/1ps

module versioning_regs #(
  parameter int unsigned NUM_COMPONENTS = 8
) (
  input  logic                                              s_ctrlport_clk,
  input  logic                                              s_ctrlport_rst,
  input  ver_pkg::ctrlport_req_t                            req,
  input  ver_pkg::component_versions_t [NUM_COMPONENTS-1:0] version_info,
  output ver_pkg::ctrlport_resp_t                           resp
);

  // 6 index bits for 64 components
  localparam int IDX_W = $clog2(ver_pkg::MAX_COMPONENTS);

  logic [IDX_W-1:0]             comp_idx;
  logic [3:0]                   reg_ofs;
  logic                         reg_known;
  ver_pkg::component_versions_t comp_sel;

  // --------------------------------------------------------------------------
  // offset decode
  // --------------------------------------------------------------------------

  // offset bits 9..4 pick the component, 3..0 the word
  assign comp_idx = req.addr[IDX_W+3:4];
  assign reg_ofs  = req.addr[3:0];

  // index range is guaranteed by the decoder window size
  assign comp_sel = version_info[comp_idx];

  // reserved and unaligned offsets are not backed by a register
  always_comb begin
    case (reg_ofs)
      ver_pkg::OFS_CURRENT:  reg_known = 1'b1;
      ver_pkg::OFS_OLDEST:   reg_known = 1'b1;
      ver_pkg::OFS_MODIFIED: reg_known = 1'b1;
      ver_pkg::OFS_RESERVED: reg_known = 1'b0;
      default:               reg_known = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // response
  // --------------------------------------------------------------------------

  // every request gets an ack one cycle later
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      resp.ack    <= 1'b0;
      resp.status <= ver_pkg::STS_OKAY;
    end else begin
      resp.ack <= req.wr | req.rd;
      // no writable registers here
      if (req.wr || !reg_known) begin
        resp.status <= ver_pkg::STS_CMDERR;
      end else begin
        resp.status <= ver_pkg::STS_OKAY;
      end
    end
  end

  // read data, zero on writes and errors
  always_ff @(posedge s_ctrlport_clk) begin
    resp.data <= '0;
    if (req.rd) begin
      case (reg_ofs)
        ver_pkg::OFS_CURRENT: begin
          resp.data <= comp_sel.current;
        end
        ver_pkg::OFS_OLDEST: begin
          resp.data <= comp_sel.oldest;
        end
        ver_pkg::OFS_MODIFIED: begin
          // timestamp word, 0xYYMMDDHH
          resp.data <= comp_sel.modified;
        end
        default: begin
          resp.data <= '0;
        end
      endcase
    end
  end

endmodule

//--- src/compat_regs.sv
// compatibility window
// host writes its own version for one component and reads back too old / too new
`timescale 1ns/1ps

module compat_regs #(
  parameter int unsigned NUM_COMPONENTS = 8
) (
  input  logic                                              s_ctrlport_clk,
  input  logic                                              s_ctrlport_rst,
  input  ver_pkg::ctrlport_req_t                            req,
  input  ver_pkg::component_versions_t [NUM_COMPONENTS-1:0] version_info,
  output ver_pkg::ctrlport_resp_t                           resp
);

  localparam int IDX_W = $clog2(ver_pkg::MAX_COMPONENTS);

  // host side registers
  logic [IDX_W-1:0]             sw_index;
  ver_pkg::version_t            sw_current;
  ver_pkg::version_t            sw_oldest;

  logic [3:0]                   reg_ofs;
  logic                         idx_bad;
  logic                         too_old;
  logic                         too_new;
  logic [2:0]                   status_bits;
  ver_pkg::component_versions_t comp_sel;

  assign reg_ofs = req.addr[3:0];

  // --------------------------------------------------------------------------
  // compatibility compare
  // --------------------------------------------------------------------------
  assign idx_bad  = 32'(sw_index) >= NUM_COMPONENTS;
  // zero record on a bad index keeps the compare clean
  assign comp_sel = idx_bad ? '0 : version_info[sw_index];

  // host needs something newer than the component has
  assign too_old = ~idx_bad & (sw_oldest > comp_sel.current);
  // component dropped support for the host's version
  assign too_new = ~idx_bad & (sw_current < comp_sel.oldest);

  assign status_bits = {idx_bad, too_new, too_old};

  // --------------------------------------------------------------------------
  // host registers
  // --------------------------------------------------------------------------
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      sw_index   <= '0;
      sw_current <= '0;
      sw_oldest  <= '0;
    end else if (req.wr) begin
      case (reg_ofs)
        ver_pkg::OFS_SW_INDEX:   sw_index   <= req.data[IDX_W-1:0];
        ver_pkg::OFS_SW_CURRENT: sw_current <= req.data;
        ver_pkg::OFS_SW_OLDEST:  sw_oldest  <= req.data;
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // response
  // --------------------------------------------------------------------------
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      resp.ack    <= 1'b0;
      resp.status <= ver_pkg::STS_OKAY;
    end else begin
      resp.ack    <= req.wr | req.rd;
      resp.status <= ver_pkg::STS_OKAY;
      case (reg_ofs)
        ver_pkg::OFS_SW_INDEX, ver_pkg::OFS_SW_CURRENT, ver_pkg::OFS_SW_OLDEST: ;
        // status is read-only
        ver_pkg::OFS_COMPAT_STATUS: begin
          if (req.wr) resp.status <= ver_pkg::STS_CMDERR;
        end
        default: resp.status <= ver_pkg::STS_CMDERR;
      endcase
    end
  end

  // read back, zero for writes
  always_ff @(posedge s_ctrlport_clk) begin
    resp.data <= '0;
    if (req.rd) begin
      case (reg_ofs)
        ver_pkg::OFS_SW_INDEX:      resp.data <= 32'(sw_index);
        ver_pkg::OFS_SW_CURRENT:    resp.data <= sw_current;
        ver_pkg::OFS_SW_OLDEST:     resp.data <= sw_oldest;
        ver_pkg::OFS_COMPAT_STATUS: resp.data <= 32'(status_bits);
        default:                    resp.data <= '0;
      endcase
    end
  end

endmodule

//--- src/version_subsystem.sv
// version subsystem top
// decoder with versioning and compatibility register windows behind it
`timescale 1ns/1ps

module version_subsystem #(
  parameter int unsigned NUM_COMPONENTS = 8,
  parameter int unsigned VERSION_BASE   = 'h0000,
  parameter int unsigned COMPAT_BASE    = 'h0400
) (
  input  logic                                              s_ctrlport_clk,
  input  logic                                              s_ctrlport_rst,
  input  ver_pkg::ctrlport_req_t                            s_ctrlport_req,
  input  ver_pkg::component_versions_t [NUM_COMPONENTS-1:0] version_info,
  output ver_pkg::ctrlport_resp_t                           s_ctrlport_resp
);

  // decoder to window requests, offsets already reduced
  ver_pkg::ctrlport_req_t  ver_req;
  ver_pkg::ctrlport_req_t  compat_req;
  // window responses back to the decoder
  ver_pkg::ctrlport_resp_t ver_resp;
  ver_pkg::ctrlport_resp_t compat_resp;

  // --------------------------------------------------------------------------
  // address decode and response merge
  // --------------------------------------------------------------------------
  ctrlport_decoder #(
    .NUM_COMPONENTS (NUM_COMPONENTS),
    .VERSION_BASE   (VERSION_BASE),
    .COMPAT_BASE    (COMPAT_BASE)
  ) decoder0 (
    .s_ctrlport_clk  (s_ctrlport_clk),
    .s_ctrlport_rst  (s_ctrlport_rst),
    .s_ctrlport_req  (s_ctrlport_req),
    .s_ctrlport_resp (s_ctrlport_resp),
    .ver_req         (ver_req),
    .compat_req      (compat_req),
    .ver_resp        (ver_resp),
    .compat_resp     (compat_resp)
  );

  // read-only version words
  versioning_regs #(
    .NUM_COMPONENTS (NUM_COMPONENTS)
  ) versioning0 (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .req            (ver_req),
    .version_info   (version_info),
    .resp           (ver_resp)
  );

  // host version check
  compat_regs #(
    .NUM_COMPONENTS (NUM_COMPONENTS)
  ) compat0 (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .req            (compat_req),
    .version_info   (version_info),
    .resp           (compat_resp)
  );

endmodule

//--- testbench/version_subsystem_chk.sv
// bound checker for the version subsystem
// control-port handshake, response latency and versioning read data
`timescale 1ns/1ps

module version_subsystem_chk #(
  parameter int unsigned NUM_COMPONENTS = 8,
  parameter int unsigned VERSION_BASE   = 'h0000,
  parameter int unsigned COMPAT_BASE    = 'h0400
) (
  input logic                         s_ctrlport_clk,
  input logic                         s_ctrlport_rst,
  input ver_pkg::ctrlport_req_t       s_ctrlport_req,
  input ver_pkg::ctrlport_resp_t      s_ctrlport_resp,
  input logic [NUM_COMPONENTS*96-1:0] version_info
);

  localparam int unsigned VER_LIMIT    = VERSION_BASE + NUM_COMPONENTS * 16;
  localparam int unsigned COMPAT_LIMIT = COMPAT_BASE + 16;

  // failure count, read by the testbench
  int unsigned assert_fails = 0;

  logic [31:0] addr;
  logic [31:0] ofs;
  logic [31:0] exp_word;
  logic        req_any;
  logic        in_ver;
  logic        mapped_req;
  logic        unmapped_req;
  logic        ver_field_rd;
  // request issued, ack not yet seen
  logic        pending;
  // from reset until the first request
  logic        quiet;

  assign addr         = 32'(s_ctrlport_req.addr);
  assign ofs          = addr - VERSION_BASE;
  assign req_any      = s_ctrlport_req.wr | s_ctrlport_req.rd;
  assign in_ver       = (addr >= VERSION_BASE) && (addr < VER_LIMIT);
  assign mapped_req   = req_any && (in_ver || ((addr >= COMPAT_BASE) && (addr < COMPAT_LIMIT)));
  assign unmapped_req = req_any && !mapped_req;
  // current, oldest or modified word of one component
  assign ver_field_rd = s_ctrlport_req.rd && in_ver && (ofs[3:2] != 2'b11) && (ofs[1:0] == 2'b00);

  // record layout is current at the bottom, then oldest, then timestamp
  always_comb begin
    exp_word = '0;
    if ((ofs[9:4] < NUM_COMPONENTS) && (ofs[3:2] != 2'b11)) begin
      exp_word = version_info[32'(ofs[9:4]) * 96 + 32'(ofs[3:2]) * 32 +: 32];
    end
  end

  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      pending <= 1'b0;
      quiet   <= 1'b1;
    end else if (req_any) begin
      pending <= 1'b1;
      quiet   <= 1'b0;
    end else if (s_ctrlport_resp.ack) begin
      pending <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // assertions
  // --------------------------------------------------------------------------
  a_ack_pulse: assert property (@(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    s_ctrlport_resp.ack |=> !s_ctrlport_resp.ack)
    else begin $error("ack longer than one cycle"); assert_fails++; end

  a_one_outstanding: assert property (@(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    pending |-> !req_any)
    else begin $error("request while one is outstanding"); assert_fails++; end

  a_mapped_ack: assert property (@(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    $past(mapped_req, 3) |-> s_ctrlport_resp.ack)
    else begin $error("mapped request not acked after 3 cycles"); assert_fails++; end

  a_mapped_early: assert property (@(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    ($past(mapped_req, 1) || $past(mapped_req, 2)) |-> !s_ctrlport_resp.ack)
    else begin $error("mapped request acked early"); assert_fails++; end

  a_unmapped_ack: assert property (@(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    $past(unmapped_req) |-> s_ctrlport_resp.ack)
    else begin $error("unmapped request not acked after 1 cycle"); assert_fails++; end

  a_ver_read: assert property (@(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    $past(ver_field_rd, 3) |-> (s_ctrlport_resp.status == ver_pkg::STS_OKAY) &&
                                (s_ctrlport_resp.data == $past(exp_word, 3)))
    else begin $error("versioning read returned wrong word or status"); assert_fails++; end

  // no disable here, the reset period itself is covered
  a_reset_quiet: assert property (@(posedge s_ctrlport_clk) quiet |-> !s_ctrlport_resp.ack)
    else begin $error("ack during or after reset before any request"); assert_fails++; end

endmodule

bind version_subsystem version_subsystem_chk #(
  .NUM_COMPONENTS (NUM_COMPONENTS),
  .VERSION_BASE   (VERSION_BASE),
  .COMPAT_BASE    (COMPAT_BASE)
) chk0 (
  .s_ctrlport_clk  (s_ctrlport_clk),
  .s_ctrlport_rst  (s_ctrlport_rst),
  .s_ctrlport_req  (s_ctrlport_req),
  .s_ctrlport_resp (s_ctrlport_resp),
  .version_info    (version_info)
);

//--- testbench/tb_version_subsystem.sv
// testbench for the version subsystem
// lfsr and directed control-port traffic over both register windows
`timescale 1ns/1ps

module tb_version_subsystem;

  localparam int unsigned NUM_COMPONENTS = 8;
  localparam logic [19:0] VERSION_BASE   = 20'h00000;
  localparam logic [19:0] COMPAT_BASE    = 20'h00400;
  localparam int unsigned LFSR_ROUNDS    = 16;
  // transactions over all tests, in order of the sequence below
  localparam int unsigned NUM_TXN        = 4 + 11 * NUM_COMPONENTS + 12 + 7 * LFSR_ROUNDS + 25 + 8;
  localparam int unsigned TIMEOUT_CYCLES = NUM_TXN * 8 + 100;
  // past the versioning range, inside no window
  localparam logic [19:0] BAD_ADDR [6] = '{VERSION_BASE + 20'(NUM_COMPONENTS * 16), 20'h00200,
                                           20'h003FC, 20'h00410, 20'h00800, 20'hFFFFC};

  logic                         s_ctrlport_clk;
  logic                         s_ctrlport_rst;
  ver_pkg::ctrlport_req_t       s_ctrlport_req;
  ver_pkg::ctrlport_resp_t      s_ctrlport_resp;
  logic [NUM_COMPONENTS*96-1:0] version_bits;

  logic [15:0] lfsr = 16'h0001;
  string       cur_test;
  int unsigned test_errs   = 0;
  int unsigned assert_base = 0;
  int unsigned pass_cnt    = 0;
  int unsigned fail_cnt    = 0;
  int unsigned cycle_cnt   = 0;

  version_subsystem dut0 (
    .s_ctrlport_clk  (s_ctrlport_clk),
    .s_ctrlport_rst  (s_ctrlport_rst),
    .s_ctrlport_req  (s_ctrlport_req),
    .version_info    (version_bits),
    .s_ctrlport_resp (s_ctrlport_resp)
  );

  initial begin
    s_ctrlport_clk = 1'b0;
    forever #2 s_ctrlport_clk = ~s_ctrlport_clk;
  end

  always @(posedge s_ctrlport_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // k is 0 current, 1 oldest, 2 modified
  function automatic logic [31:0] field_of(input int unsigned c, input int unsigned k);
    return version_bits[c*96 + k*32 +: 32];
  endfunction

  function automatic logic [19:0] ver_addr(input int unsigned c, input logic [3:0] ofs);
    return VERSION_BASE + 20'(c * 16) + 20'(ofs);
  endfunction

  function automatic logic [19:0] compat_addr(input logic [3:0] ofs);
    return COMPAT_BASE + 20'(ofs);
  endfunction

  // bit 0 too old, bit 1 too new, bit 2 bad index
  function automatic logic [31:0] expected_status(input logic [31:0] idx, input logic [31:0] cur,
                                                  input logic [31:0] old);
    if (idx >= NUM_COMPONENTS) return 32'h4;
    return {30'd0, cur < field_of(idx, 1), old > field_of(idx, 0)};
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  // one request, then wait for its ack; entered 1 ns after a rising edge
  task automatic bus_txn(input logic wr, input logic [19:0] addr, input logic [31:0] wdata,
                         input logic [1:0] exp_sts, input logic [31:0] exp_data,
                         input int exp_lat);
    int   lat;
    logic got;
    s_ctrlport_req.wr   = wr;
    s_ctrlport_req.rd   = ~wr;
    s_ctrlport_req.addr = addr;
    s_ctrlport_req.data = wdata;
    lat = 0;
    got = 1'b0;
    while (!got && lat < 8) begin
      @(posedge s_ctrlport_clk);
      #1;
      lat++;
      s_ctrlport_req.wr = 1'b0;
      s_ctrlport_req.rd = 1'b0;
      got = s_ctrlport_resp.ack;
    end
    if (!got) begin
      $display("%s: no acknowledge within 8 cycles at address 0x%05h", cur_test, addr);
      test_errs++;
    end else begin
      check_value("latency", 32'(exp_lat), 32'(lat));
      check_value("status", 32'(exp_sts), 32'(s_ctrlport_resp.status));
      check_value("data", exp_data, s_ctrlport_resp.data);
    end
    // next request goes out on the cycle after the ack
    @(posedge s_ctrlport_clk);
    #1;
  endtask

  task automatic read_reg(input logic [19:0] addr, input logic [1:0] exp_sts,
                          input logic [31:0] exp_data, input int exp_lat);
    bus_txn(1'b0, addr, 32'd0, exp_sts, exp_data, exp_lat);
  endtask

  // writes return no data
  task automatic write_reg(input logic [19:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_sts, input int exp_lat);
    bus_txn(1'b1, addr, data, exp_sts, 32'd0, exp_lat);
  endtask

  task automatic compat_check(input logic [31:0] idx, input logic [31:0] cur,
                              input logic [31:0] old, input logic readback);
    write_reg(compat_addr(ver_pkg::OFS_SW_INDEX), idx, ver_pkg::STS_OKAY, 3);
    write_reg(compat_addr(ver_pkg::OFS_SW_CURRENT), cur, ver_pkg::STS_OKAY, 3);
    write_reg(compat_addr(ver_pkg::OFS_SW_OLDEST), old, ver_pkg::STS_OKAY, 3);
    if (readback) begin
      read_reg(compat_addr(ver_pkg::OFS_SW_INDEX), ver_pkg::STS_OKAY, idx & 32'h3F, 3);
      read_reg(compat_addr(ver_pkg::OFS_SW_CURRENT), ver_pkg::STS_OKAY, cur, 3);
      read_reg(compat_addr(ver_pkg::OFS_SW_OLDEST), ver_pkg::STS_OKAY, old, 3);
    end
    read_reg(compat_addr(ver_pkg::OFS_COMPAT_STATUS), ver_pkg::STS_OKAY,
             expected_status(idx & 32'h3F, cur, old), 3);
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errs   = 0;
    assert_base = dut0.chk0.assert_fails;
  endtask

  task automatic end_test();
    test_errs += dut0.chk0.assert_fails - assert_base;
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s passed", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] idx;
    logic [31:0] cur;
    logic [31:0] old;
    s_ctrlport_rst = 1'b1;
    s_ctrlport_req = '0;
    // component records straight from the lfsr, one step per bit
    for (int i = 0; i < NUM_COMPONENTS * 96; i++) begin
      lfsr = lfsr_step(lfsr);
      version_bits[i] = lfsr[0];
    end
    repeat (3) @(posedge s_ctrlport_clk);
    #1;
    s_ctrlport_rst = 1'b0;

    begin_test("reset_values");
    check_value("reset ack", 32'd0, 32'(s_ctrlport_resp.ack));
    read_reg(compat_addr(ver_pkg::OFS_SW_INDEX), ver_pkg::STS_OKAY, 32'd0, 3);
    read_reg(compat_addr(ver_pkg::OFS_SW_CURRENT), ver_pkg::STS_OKAY, 32'd0, 3);
    read_reg(compat_addr(ver_pkg::OFS_SW_OLDEST), ver_pkg::STS_OKAY, 32'd0, 3);
    read_reg(compat_addr(ver_pkg::OFS_COMPAT_STATUS), ver_pkg::STS_OKAY,
             expected_status(0, 0, 0), 3);
    end_test();

    begin_test("version_reads");
    for (int c = 0; c < NUM_COMPONENTS; c++) begin
      for (int k = 0; k < 3; k++) begin
        read_reg(ver_addr(c, 4'(k * 4)), ver_pkg::STS_OKAY, field_of(c, k), 3);
      end
    end
    end_test();

    // writes and the reserved word are rejected, contents stay
    begin_test("version_errors");
    for (int c = 0; c < NUM_COMPONENTS; c++) begin
      for (int k = 0; k < 4; k++) begin
        take_bits(32, cur);
        write_reg(ver_addr(c, 4'(k * 4)), cur, ver_pkg::STS_CMDERR, 3);
      end
      read_reg(ver_addr(c, ver_pkg::OFS_RESERVED), ver_pkg::STS_CMDERR, 32'd0, 3);
    end
    for (int c = 0; c < NUM_COMPONENTS; c++) begin
      for (int k = 0; k < 3; k++) begin
        read_reg(ver_addr(c, 4'(k * 4)), ver_pkg::STS_OKAY, field_of(c, k), 3);
      end
    end
    end_test();

    begin_test("unmapped_access");
    foreach (BAD_ADDR[i]) begin
      read_reg(BAD_ADDR[i], ver_pkg::STS_CMDERR, 32'd0, 1);
      write_reg(BAD_ADDR[i], 32'hA5A5_5A5A, ver_pkg::STS_CMDERR, 1);
    end
    end_test();

    // 4 index bits, so about half the indices are out of range
    begin_test("compat_random");
    for (int r = 0; r < LFSR_ROUNDS; r++) begin
      take_bits(4, idx);
      take_bits(32, cur);
      take_bits(32, old);
      compat_check(idx, cur, old, 1'b1);
    end
    end_test();

    // equal, greater and smaller against component 2
    begin_test("compat_directed");
    cur = field_of(2, 0);
    old = field_of(2, 1);
    compat_check(2, old, cur, 1'b0);
    compat_check(2, old, cur + 1, 1'b0);
    compat_check(2, old - 1, cur, 1'b0);
    compat_check(2, old - 1, cur + 1, 1'b0);
    compat_check(NUM_COMPONENTS, 0, 0, 1'b0);
    compat_check(63, old, cur, 1'b0);
    write_reg(compat_addr(ver_pkg::OFS_COMPAT_STATUS), 32'h7, ver_pkg::STS_CMDERR, 3);
    end_test();

    // each request on the cycle after the previous ack
    begin_test("back_to_back");
    repeat (2) begin
      read_reg(ver_addr(1, ver_pkg::OFS_CURRENT), ver_pkg::STS_OKAY, field_of(1, 0), 3);
      read_reg(BAD_ADDR[0], ver_pkg::STS_CMDERR, 32'd0, 1);
      read_reg(compat_addr(ver_pkg::OFS_SW_INDEX), ver_pkg::STS_OKAY, 32'd63, 3);
      read_reg(20'h00500, ver_pkg::STS_CMDERR, 32'd0, 1);
    end
    end_test();

    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb.f
src/ver_pkg.sv
src/ctrlport_decoder.sv
src/versioning_regs.sv
src/compat_regs.sv
src/version_subsystem.sv
testbench/version_subsystem_chk.sv
testbench/tb_version_subsystem.sv

//--- Bender.yml
package:
  name: version_subsystem

dependencies: {}

sources:
  - src/ver_pkg.sv
  - src/ctrlport_decoder.sv
  - src/versioning_regs.sv
  - src/compat_regs.sv
  - src/version_subsystem.sv
  - target: test
    files:
      - testbench/version_subsystem_chk.sv
      - testbench/tb_version_subsystem.sv
